/* logic/mmc_proto_pkg.sv */
// Card protocol constants for SPI mode only. CRC is checked on CMD0 alone and sent as filler.
package mmc_proto_pkg;

   // Byte operations of the external SPI engine.
   typedef enum logic [2:0] {
      op_none = 3'd0,
      op_init = 3'd1,
      op_send = 3'd2,
      op_rd   = 3'd3,
      op_wr   = 3'd4,
      op_stop = 3'd5
   } mmc_op_e;

   // Index byte, 32-bit argument, CRC byte with stop bit.
   typedef logic [47:0] mmc_frame_t;

   localparam mmc_frame_t cmd_go_idle      = 48'h40_0000_0000_95;
   localparam mmc_frame_t cmd_send_op_cond = 48'h41_0000_0000_01;
   localparam mmc_frame_t cmd_set_blocklen = 48'h50_0000_0200_01;

   localparam logic [7:0] cmd_read_single  = 8'h51;
   localparam logic [7:0] cmd_write_single = 8'h58;
   localparam logic [7:0] frame_stop_byte  = 8'h01;

   localparam logic [7:0] r1_idle  = 8'h01;
   localparam logic [7:0] r1_ready = 8'h00;
   localparam logic [7:0] r1_none  = 8'hff;

   localparam logic [7:0] tok_data_start = 8'hfe;
   localparam logic [7:0] crc_fill       = 8'h00;
   localparam logic [2:0] dresp_accepted = 3'b010;

endpackage

/* logic/block_dev_pkg.sv */
// Host-side geometry. Fixed at two blocks of 512 bytes per request and byte addressed cards.
package block_dev_pkg;

   // Host request codes as carried on bd_cmd.
   typedef enum logic [1:0] {
      req_reset    = 2'd0,
      req_read     = 2'd1,
      req_write    = 2'd2,
      req_reserved = 2'd3
   } bd_op_e;

   localparam int block_addr_w = 23;

   typedef logic [31:0] byte_addr_t;
   typedef logic [15:0] bd_word_t;

   localparam int words_per_block    = 256;
   localparam int blocks_per_request = 2;
   localparam int block_bytes        = 512;

endpackage

/* logic/block_dev_ifs.sv */
// Internal buses only. No clock inside, so all timing follows the modules that drive them.
`timescale 1ns/1ps

// Request capture to card sequencer.
interface req_if;
   logic                       start_pulse;
   block_dev_pkg::bd_op_e      op;
   block_dev_pkg::byte_addr_t  byte_addr;
   logic                       next_block;

   modport source (output start_pulse, output op, output byte_addr, input next_block);
   modport sink (input start_pulse, input op, input byte_addr, output next_block);
endinterface

// Card sequencer to block data path.
interface xfer_if;
   logic                     take_host_word;
   logic                     take_low;
   logic                     take_high;
   logic [7:0]               rx_byte;
   logic                     clear_words;
   logic                     step_word;
   logic                     step_block;
   logic                     clear_blocks;
   block_dev_pkg::bd_word_t  held_word;
   block_dev_pkg::bd_word_t  rx_word;
   logic                     last_word;
   logic                     last_block;

   modport control (
      output take_host_word, take_low, take_high, rx_byte,
      output clear_words, step_word, step_block, clear_blocks,
      input  held_word, rx_word, last_word, last_block
   );
   modport data (
      input  take_host_word, take_low, take_high, rx_byte,
      input  clear_words, step_word, step_block, clear_blocks,
      output held_word, rx_word, last_word, last_block
   );
endinterface

/* logic/bd_request_capture.sv */
// Latches one request per start strobe. bd_addr bit 23 is ignored, so addresses wrap at 4 GB.
`timescale 1ns/1ps

module bd_request_capture (
   input  logic        clk,
   input  logic        reset,
   input  logic        bd_start,
   input  logic [1:0]  bd_cmd,
   input  logic [23:0] bd_addr,
   req_if.source       req
);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         req.start_pulse <= 1'b0;
         req.op          <= block_dev_pkg::req_reset;
         req.byte_addr   <= '0;
      end
      else
      begin
         req.start_pulse <= bd_start;
         if (bd_start)
         begin
            req.op        <= block_dev_pkg::bd_op_e'(bd_cmd);
            // Block number to byte address.
            req.byte_addr <= block_dev_pkg::byte_addr_t'(bd_addr[block_dev_pkg::block_addr_w-1:0])
                             * block_dev_pkg::byte_addr_t'(block_dev_pkg::block_bytes);
         end
         else if (req.next_block)
         begin
            req.byte_addr <= req.byte_addr
                             + block_dev_pkg::byte_addr_t'(block_dev_pkg::block_bytes);
         end
      end
   end

endmodule

/* logic/card_sequencer.sv */
// One request at a time. A card that never answers hangs the FSM, since there is no timeout.
`timescale 1ns/1ps

module card_sequencer (
   input  logic                      clk,
   input  logic                      reset,
   req_if.sink                       req,
   xfer_if.control                   xfer,
   input  logic [7:0]                mmc_out,
   input  logic                      mmc_done,
   output logic                      mmc_init,
   output logic                      mmc_send,
   output logic                      mmc_rd,
   output logic                      mmc_wr,
   output logic                      mmc_stop,
   output mmc_proto_pkg::mmc_frame_t mmc_cmd,
   output logic [7:0]                mmc_in,
   output logic                      bd_bsy,
   output logic                      bd_rdy,
   output logic                      bd_iordy,
   output logic                      bd_err,
   input  logic                      bd_rd,
   input  logic                      bd_wr
);

   typedef enum logic [4:0] {
      st_idle, st_init, st_cmd0, st_cmd0_r1, st_cmd0_stop,
      st_cmd1, st_cmd1_r1, st_cmd1_stop, st_cmd1_retry,
      st_cmd16, st_cmd16_r1, st_cmd16_stop,
      st_blk_cmd, st_blk_r1,
      st_rd_token, st_rd_low, st_rd_high, st_rd_host, st_rd_crc0, st_rd_crc1,
      st_wr_token, st_wr_host, st_wr_low, st_wr_high, st_wr_ack,
      st_wr_crc0, st_wr_crc1, st_wr_dresp, st_wr_busy,
      st_blk_stop, st_blk_next, st_abort
   } state_e;

   state_e                  state;
   state_e                  state_next;
   mmc_proto_pkg::mmc_op_e  op;
   logic                    wait_high;
   logic                    op_fin;
   logic                    inited;
   logic                    err;
   logic                    set_err;
   logic                    set_inited;
   logic                    is_write;

   assign is_write = (req.op == block_dev_pkg::req_write);

   // Byte operation and its operand for each state.
   always_comb
   begin
      op = mmc_proto_pkg::op_none;
      mmc_cmd = '0;
      mmc_in = mmc_proto_pkg::crc_fill;
      case (state)
         st_init:
            op = mmc_proto_pkg::op_init;
         st_cmd0:
         begin
            op = mmc_proto_pkg::op_send;
            mmc_cmd = mmc_proto_pkg::cmd_go_idle;
         end
         st_cmd1:
         begin
            op = mmc_proto_pkg::op_send;
            mmc_cmd = mmc_proto_pkg::cmd_send_op_cond;
         end
         st_cmd16:
         begin
            op = mmc_proto_pkg::op_send;
            mmc_cmd = mmc_proto_pkg::cmd_set_blocklen;
         end
         st_blk_cmd:
         begin
            op = mmc_proto_pkg::op_send;
            mmc_cmd = {is_write ? mmc_proto_pkg::cmd_write_single
                                : mmc_proto_pkg::cmd_read_single,
                       req.byte_addr, mmc_proto_pkg::frame_stop_byte};
         end
         st_cmd0_r1, st_cmd1_r1, st_cmd16_r1, st_blk_r1, st_rd_token, st_rd_low,
         st_rd_high, st_rd_crc0, st_rd_crc1, st_wr_dresp, st_wr_busy:
            op = mmc_proto_pkg::op_rd;
         st_wr_token:
         begin
            op = mmc_proto_pkg::op_wr;
            mmc_in = mmc_proto_pkg::tok_data_start;
         end
         st_wr_low:
         begin
            op = mmc_proto_pkg::op_wr;
            mmc_in = xfer.held_word[7:0];
         end
         st_wr_high:
         begin
            op = mmc_proto_pkg::op_wr;
            mmc_in = xfer.held_word[15:8];
         end
         st_wr_crc0, st_wr_crc1:
            op = mmc_proto_pkg::op_wr;
         st_cmd0_stop, st_cmd1_stop, st_cmd1_retry, st_cmd16_stop, st_blk_stop, st_abort:
            op = mmc_proto_pkg::op_stop;
         default:
            op = mmc_proto_pkg::op_none;
      endcase
   end

   // Strobe held until done drops, then wait for done to rise again.
   assign mmc_init = !wait_high && (op == mmc_proto_pkg::op_init);
   assign mmc_send = !wait_high && (op == mmc_proto_pkg::op_send);
   assign mmc_rd   = !wait_high && (op == mmc_proto_pkg::op_rd);
   assign mmc_wr   = !wait_high && (op == mmc_proto_pkg::op_wr);
   assign mmc_stop = !wait_high && (op == mmc_proto_pkg::op_stop);
   assign op_fin   = wait_high && mmc_done;

   assign bd_bsy   = (state != st_idle);
   assign bd_rdy   = (state == st_idle) || (state == st_wr_host) || (state == st_rd_low)
                     || (state == st_rd_high) || (state == st_rd_host);
   assign bd_iordy = (state == st_rd_host) || (state == st_wr_ack);
   assign bd_err   = err;
   assign xfer.rx_byte = mmc_out;

   always_comb
   begin
      state_next = state;
      set_err = 1'b0;
      set_inited = 1'b0;
      req.next_block = 1'b0;
      xfer.take_host_word = 1'b0;
      xfer.take_low = 1'b0;
      xfer.take_high = 1'b0;
      xfer.clear_words = 1'b0;
      xfer.step_word = 1'b0;
      xfer.step_block = 1'b0;
      xfer.clear_blocks = 1'b0;
      case (state)
         st_idle:
            if (req.start_pulse)
            begin
               xfer.clear_blocks = 1'b1;
               case (req.op)
                  block_dev_pkg::req_reset:
                     state_next = st_init;
                  block_dev_pkg::req_read, block_dev_pkg::req_write:
                     state_next = inited ? st_blk_cmd : st_init;
                  default:
                     state_next = st_idle;
               endcase
            end
         st_init:
            if (op_fin) state_next = st_cmd0;
         st_cmd0:
            if (op_fin) state_next = st_cmd0_r1;
         st_cmd0_r1:
            if (op_fin)
            begin
               if (mmc_out == mmc_proto_pkg::r1_idle)
                  state_next = st_cmd0_stop;
               else if (!mmc_out[7])
                  state_next = st_init;
               else
                  state_next = st_cmd0_r1;
            end
         st_cmd0_stop:
            if (op_fin) state_next = st_cmd1;
         st_cmd1:
            if (op_fin) state_next = st_cmd1_r1;
         st_cmd1_r1:
            if (op_fin)
            begin
               if (mmc_out == mmc_proto_pkg::r1_ready)
                  state_next = st_cmd1_stop;
               else if (mmc_out != mmc_proto_pkg::r1_none)
                  state_next = st_cmd1_retry;
            end
         st_cmd1_retry:
            if (op_fin) state_next = st_cmd1;
         st_cmd1_stop:
            if (op_fin) state_next = st_cmd16;
         st_cmd16:
            if (op_fin) state_next = st_cmd16_r1;
         st_cmd16_r1:
            if (op_fin && mmc_out == mmc_proto_pkg::r1_ready) state_next = st_cmd16_stop;
         st_cmd16_stop:
            if (op_fin)
            begin
               set_inited = 1'b1;
               state_next = (req.op == block_dev_pkg::req_reset) ? st_idle : st_blk_cmd;
            end
         st_blk_cmd:
            if (op_fin) state_next = st_blk_r1;
         st_blk_r1:
            if (op_fin)
            begin
               if (mmc_out == mmc_proto_pkg::r1_ready)
               begin
                  xfer.clear_words = 1'b1;
                  state_next = is_write ? st_wr_token : st_rd_token;
               end
               else if (mmc_out != mmc_proto_pkg::r1_none)
               begin
                  set_err = 1'b1;
                  state_next = st_abort;
               end
            end
         st_rd_token:
            if (op_fin)
            begin
               if (mmc_out == mmc_proto_pkg::tok_data_start)
                  state_next = st_rd_low;
               else if (mmc_out != mmc_proto_pkg::r1_none)
               begin
                  // Data error token.
                  set_err = 1'b1;
                  state_next = st_abort;
               end
            end
         st_rd_low:
            if (op_fin)
            begin
               xfer.take_low = 1'b1;
               state_next = st_rd_high;
            end
         st_rd_high:
            if (op_fin)
            begin
               xfer.take_high = 1'b1;
               state_next = st_rd_host;
            end
         st_rd_host:
            if (bd_rd)
            begin
               xfer.step_word = 1'b1;
               state_next = xfer.last_word ? st_rd_crc0 : st_rd_low;
            end
         st_rd_crc0:
            if (op_fin) state_next = st_rd_crc1;
         st_rd_crc1:
            if (op_fin) state_next = st_blk_stop;
         st_wr_token:
            if (op_fin) state_next = st_wr_host;
         st_wr_host:
            if (bd_wr)
            begin
               xfer.take_host_word = 1'b1;
               state_next = st_wr_low;
            end
         st_wr_low:
            if (op_fin) state_next = st_wr_high;
         st_wr_high:
            if (op_fin) state_next = st_wr_ack;
         st_wr_ack:
            if (!bd_wr)
            begin
               xfer.step_word = 1'b1;
               state_next = xfer.last_word ? st_wr_crc0 : st_wr_host;
            end
         st_wr_crc0:
            if (op_fin) state_next = st_wr_crc1;
         st_wr_crc1:
            if (op_fin) state_next = st_wr_dresp;
         st_wr_dresp:
            if (op_fin)
            begin
               // Only a well formed response is judged.
               if (!mmc_out[4] && mmc_out[0] && mmc_out[3:1] != mmc_proto_pkg::dresp_accepted)
                  set_err = 1'b1;
               state_next = st_wr_busy;
            end
         st_wr_busy:
            if (op_fin && mmc_out != 8'h00) state_next = st_blk_stop;
         st_blk_stop:
            if (op_fin) state_next = st_blk_next;
         st_blk_next:
         begin
            xfer.step_block = 1'b1;
            req.next_block = 1'b1;
            state_next = xfer.last_block ? st_idle : st_blk_cmd;
         end
         st_abort:
            if (op_fin) state_next = st_idle;
         default:
            state_next = st_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= st_idle;
         wait_high <= 1'b0;
         inited <= 1'b0;
         err <= 1'b0;
      end
      else
      begin
         state <= state_next;
         if (op != mmc_proto_pkg::op_none && !wait_high && !mmc_done)
            wait_high <= 1'b1;
         else if (op_fin)
            wait_high <= 1'b0;
         if (set_inited)
            inited <= 1'b1;
         // Error stays visible until the next request.
         if (req.start_pulse)
            err <= 1'b0;
         else if (set_err)
            err <= 1'b1;
      end
   end

endmodule

/* logic/block_data_path.sv */
// Word counter wraps after the last word. Read data holds its value until the next card byte.
`timescale 1ns/1ps

module block_data_path (
   input  logic        clk,
   input  logic        reset,
   input  logic [15:0] bd_data_in,
   xfer_if.data        xfer,
   output logic [15:0] bd_data_out
);

   localparam int word_cnt_w  = $clog2(block_dev_pkg::words_per_block);
   localparam int block_cnt_w = $clog2(block_dev_pkg::blocks_per_request);

   logic [word_cnt_w-1:0]  word_cnt;
   logic [block_cnt_w-1:0] block_cnt;

   // Host word for the card, and card bytes for the host.
   always_ff @(posedge clk)
   begin
      if (xfer.take_host_word)
         xfer.held_word <= bd_data_in;
      if (xfer.take_low)
         xfer.rx_word[7:0] <= xfer.rx_byte;
      if (xfer.take_high)
         xfer.rx_word[15:8] <= xfer.rx_byte;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         word_cnt <= '0;
         block_cnt <= '0;
      end
      else
      begin
         if (xfer.clear_words)
            word_cnt <= '0;
         else if (xfer.step_word)
            word_cnt <= word_cnt + 1'b1;
         if (xfer.clear_blocks)
            block_cnt <= '0;
         else if (xfer.step_block)
            block_cnt <= block_cnt + 1'b1;
      end
   end

   assign xfer.last_word  = (word_cnt == word_cnt_w'(block_dev_pkg::words_per_block - 1));
   assign xfer.last_block = (block_cnt == block_cnt_w'(block_dev_pkg::blocks_per_request - 1));
   assign bd_data_out = xfer.rx_word;

endmodule

/* logic/mmc_block_dev.sv */
// SPI byte engine sits outside. Each engine operation must end with mmc_done rising again.
`timescale 1ns/1ps

module mmc_block_dev (
   input  logic        clk,
   input  logic        reset,
   input  logic [1:0]  bd_cmd,
   input  logic        bd_start,
   input  logic [23:0] bd_addr,
   input  logic [15:0] bd_data_in,
   input  logic        bd_rd,
   input  logic        bd_wr,
   output logic        bd_bsy,
   output logic        bd_rdy,
   output logic        bd_err,
   output logic        bd_iordy,
   output logic [15:0] bd_data_out,
   output logic        mmc_init,
   output logic        mmc_send,
   output logic        mmc_rd,
   output logic        mmc_wr,
   output logic        mmc_stop,
   output logic [47:0] mmc_cmd,
   output logic [7:0]  mmc_in,
   input  logic [7:0]  mmc_out,
   input  logic        mmc_done
);

   req_if  req_bus ();
   xfer_if xfer_bus ();

   bd_request_capture u_capture (
      .clk      (clk),
      .reset    (reset),
      .bd_start (bd_start),
      .bd_cmd   (bd_cmd),
      .bd_addr  (bd_addr),
      .req      (req_bus.source)
   );

   card_sequencer u_sequencer (
      .clk      (clk),
      .reset    (reset),
      .req      (req_bus.sink),
      .xfer     (xfer_bus.control),
      .mmc_out  (mmc_out),
      .mmc_done (mmc_done),
      .mmc_init (mmc_init),
      .mmc_send (mmc_send),
      .mmc_rd   (mmc_rd),
      .mmc_wr   (mmc_wr),
      .mmc_stop (mmc_stop),
      .mmc_cmd  (mmc_cmd),
      .mmc_in   (mmc_in),
      .bd_bsy   (bd_bsy),
      .bd_rdy   (bd_rdy),
      .bd_iordy (bd_iordy),
      .bd_err   (bd_err),
      .bd_rd    (bd_rd),
      .bd_wr    (bd_wr)
   );

   block_data_path u_data_path (
      .clk         (clk),
      .reset       (reset),
      .bd_data_in  (bd_data_in),
      .xfer        (xfer_bus.data),
      .bd_data_out (bd_data_out)
   );

endmodule

/* sim/card_model.sv */
// SPI engine and card model for the testbench only. No CRC check, and a stop drops pending bytes.
`timescale 1ns/1ps

module card_model (
   input  logic        clk,
   input  logic        reset,
   input  logic [1:0]  script,
   input  logic        new_test,
   input  logic        mmc_init,
   input  logic        mmc_send,
   input  logic        mmc_rd,
   input  logic        mmc_wr,
   input  logic        mmc_stop,
   input  logic [47:0] mmc_cmd,
   input  logic [7:0]  mmc_in,
   output logic [7:0]  mmc_out,
   output logic        mmc_done
);

   logic [47:0] frames[$];
   logic [7:0]  wr_log[$];
   logic [7:0]  data_log[$];
   logic [7:0]  resp_q[$];
   int          op_count;
   int          cmd1_count;
   int          wr_count;

   task automatic serve_command(input logic [47:0] frame);
      logic [7:0] b;
      frames.push_back(frame);
      if (frame[47:40] == 8'h40)
      begin
         resp_q.push_back(8'hff);
         resp_q.push_back(8'h01);
      end
      else if (frame[47:40] == 8'h41)
      begin
         // First CMD1 of script 1 is refused once.
         if (script == 2'd1 && cmd1_count == 0)
         begin
            resp_q.push_back(8'hff);
            resp_q.push_back(8'h05);
         end
         else
            resp_q.push_back(8'h00);
         cmd1_count++;
      end
      else if ((frame[47:40] == mmc_proto_pkg::cmd_read_single
                || frame[47:40] == mmc_proto_pkg::cmd_write_single) && script == 2'd2)
         resp_q.push_back(8'h04);
      else if (frame[47:40] == mmc_proto_pkg::cmd_read_single)
      begin
         resp_q.push_back(8'h00);
         resp_q.push_back(8'hff);
         resp_q.push_back(8'hfe);
         for (int i = 0; i < block_dev_pkg::block_bytes; i++)
         begin
            b = 8'($urandom);
            data_log.push_back(b);
            resp_q.push_back(b);
         end
         resp_q.push_back(8'($urandom));
         resp_q.push_back(8'($urandom));
      end
      else
      begin
         resp_q.push_back(8'h00);
         wr_count = 0;
      end
   endtask

   task automatic take_write_byte(input logic [7:0] b);
      wr_log.push_back(b);
      wr_count++;
      // Answer after token, block data and both CRC bytes.
      if (wr_count == block_dev_pkg::block_bytes + 3)
      begin
         resp_q.push_back((script == 2'd3) ? 8'h0b : 8'h05);
         resp_q.push_back(8'h00);
         resp_q.push_back(8'hff);
      end
   endtask

   initial
   begin
      logic       clear_now;
      logic       is_rd;
      logic [7:0] rbyte;
      int         delay;
      mmc_out = 8'hff;
      mmc_done = 1'b1;
      op_count = 0;
      cmd1_count = 0;
      wr_count = 0;
      forever
      begin
         @(posedge clk);
         clear_now = new_test;
         #1;
         if (clear_now)
         begin
            frames.delete();
            wr_log.delete();
            data_log.delete();
            resp_q.delete();
            op_count = 0;
            cmd1_count = 0;
         end
         if (!reset && mmc_done && (mmc_init || mmc_send || mmc_rd || mmc_wr || mmc_stop))
         begin
            op_count++;
            is_rd = mmc_rd;
            rbyte = 8'hff;
            if (mmc_send)
               serve_command(mmc_cmd);
            else if (mmc_wr)
               take_write_byte(mmc_in);
            else if (mmc_stop)
               resp_q.delete();
            else if (mmc_rd && resp_q.size() > 0)
               rbyte = resp_q.pop_front();
            mmc_done = 1'b0;
            delay = 1 + int'($urandom % 4);
            repeat (delay) @(posedge clk);
            #1;
            if (is_rd)
               mmc_out = rbyte;
            mmc_done = 1'b1;
         end
      end
   end

endmodule

/* sim/tb_mmc_block_dev.sv */
// Run from the project root so the trace path resolves. Card delays and data come from $urandom.
`timescale 1ns/1ps

module tb_mmc_block_dev;

   localparam int clk_period      = 4;
   localparam int per_test_cycles = 2 * 512 * 2 * 5 + 2000;

   logic        clk;
   logic        reset;
   logic [1:0]  bd_cmd;
   logic        bd_start;
   logic [23:0] bd_addr;
   logic [15:0] bd_data_in;
   logic        bd_rd;
   logic        bd_wr;
   logic        bd_bsy;
   logic        bd_rdy;
   logic        bd_err;
   logic        bd_iordy;
   logic [15:0] bd_data_out;
   logic        mmc_init;
   logic        mmc_send;
   logic        mmc_rd;
   logic        mmc_wr;
   logic        mmc_stop;
   logic [47:0] mmc_cmd;
   logic [7:0]  mmc_in;
   logic [7:0]  mmc_out;
   logic        mmc_done;
   logic [1:0]  script;
   logic        new_test;

   string       test_name;
   int          n_tests;
   int          errors;
   int          test_errs;
   int          failed_tests;
   bit          trace_ready;
   bit          card_ready;
   logic [47:0] exp_frames[$];
   logic [7:0]  exp_bytes[$];
   logic [15:0] wr_words[$];
   logic [15:0] rd_words[$];

   mmc_block_dev u_dut (.*);

   card_model u_card (.*);

   initial
   begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act)
      begin
         $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
         errors++;
         test_errs++;
      end
   endtask

   task automatic add_init_frames(input int scr);
      exp_frames.push_back(48'h40_0000_0000_95);
      exp_frames.push_back(48'h41_0000_0000_01);
      if (scr == 1)
         exp_frames.push_back(48'h41_0000_0000_01);
      exp_frames.push_back(48'h50_0000_0200_01);
   endtask

   // One host cycle, 1 ns after the clock edge.
   task automatic host_step(input int op, inout int next_word);
      if (bd_rd)
         bd_rd = 1'b0;
      else if (bd_iordy && op == 1)
      begin
         rd_words.push_back(bd_data_out);
         bd_rd = 1'b1;
      end
      if (bd_wr && bd_iordy)
         bd_wr = 1'b0;
      else if (!bd_wr && bd_rdy && !bd_iordy && op == 2 && next_word < wr_words.size())
      begin
         bd_data_in = wr_words[next_word];
         bd_wr = 1'b1;
         next_word++;
      end
   endtask

   task automatic run_test(input int op, input logic [23:0] addr, input int scr, input int exp_err);
      logic [31:0] base;
      logic [15:0] card_word;
      int          blocks;
      int          next_word;
      bit          r1_fail;
      test_errs = 0;
      next_word = 0;
      exp_frames.delete();
      exp_bytes.delete();
      wr_words.delete();
      rd_words.delete();
      r1_fail = (scr == 2);
      blocks = r1_fail ? 1 : 2;
      base = 32'(addr[22:0]) * 32'd512;
      if (op == 0 || (op != 3 && !card_ready))
      begin
         add_init_frames(scr);
         card_ready = 1'b1;
      end
      if (op == 1 || op == 2)
         for (int k = 0; k < blocks; k++)
            exp_frames.push_back({(op == 2) ? 8'h58 : 8'h51, base + 32'(k * 512), 8'h01});
      if (op == 2)
         for (int i = 0; i < 512; i++)
            wr_words.push_back(16'($urandom));
      if (op == 2 && !r1_fail)
         for (int k = 0; k < 2; k++)
         begin
            exp_bytes.push_back(8'hfe);
            for (int i = 0; i < 256; i++)
            begin
               exp_bytes.push_back(wr_words[k * 256 + i][7:0]);
               exp_bytes.push_back(wr_words[k * 256 + i][15:8]);
            end
            exp_bytes.push_back(8'h00);
            exp_bytes.push_back(8'h00);
         end
      @(posedge clk);
      #1;
      script = 2'(scr);
      new_test = 1'b1;
      @(posedge clk);
      #1;
      new_test = 1'b0;
      bd_cmd = 2'(op);
      bd_addr = addr;
      bd_start = 1'b1;
      @(posedge clk);
      #1;
      bd_start = 1'b0;
      @(posedge clk);
      #1;
      check("busy after start", 64'(op != 3), 64'(bd_bsy));
      check("error cleared by start", 64'(0), 64'(bd_err));
      if (op == 3)
      begin
         // Nothing to wait for, so watch a few cycles.
         repeat (8)
         begin
            @(posedge clk);
            #1;
            check("busy on reserved opcode", 64'(0), 64'(bd_bsy));
         end
      end
      while (bd_bsy)
      begin
         host_step(op, next_word);
         @(posedge clk);
         #1;
      end
      bd_rd = 1'b0;
      bd_wr = 1'b0;
      check("error flag", 64'(exp_err), 64'(bd_err));
      check("ready when idle", 64'(1), 64'(bd_rdy));
      if (op == 3)
         check("byte operations", 64'(0), 64'(u_card.op_count));
      check("frame count", 64'(exp_frames.size()), 64'(u_card.frames.size()));
      for (int k = 0; k < exp_frames.size() && k < u_card.frames.size(); k++)
         check($sformatf("frame %0d", k), 64'(exp_frames[k]), 64'(u_card.frames[k]));
      check("written byte count", 64'(exp_bytes.size()), 64'(u_card.wr_log.size()));
      for (int k = 0; k < exp_bytes.size() && k < u_card.wr_log.size(); k++)
         check($sformatf("written byte %0d", k), 64'(exp_bytes[k]), 64'(u_card.wr_log[k]));
      check("read word count", 64'((op == 1 && !r1_fail) ? 512 : 0), 64'(rd_words.size()));
      for (int k = 0; k < rd_words.size() && 2 * k + 1 < u_card.data_log.size(); k++)
      begin
         card_word = {u_card.data_log[2 * k + 1], u_card.data_log[2 * k]};
         check($sformatf("read word %0d", k), 64'(card_word), 64'(rd_words[k]));
      end
   endtask

   initial
   begin
      int          fd;
      int          n;
      int          op_v;
      int          scr_v;
      int          err_v;
      logic [23:0] addr_v;
      string       line;
      string       name_v;
      string       t_names[$];
      int          t_ops[$];
      logic [23:0] t_addrs[$];
      int          t_scripts[$];
      int          t_errs[$];
      reset = 1'b1;
      bd_cmd = 2'd0;
      bd_start = 1'b0;
      bd_addr = 24'd0;
      bd_data_in = 16'd0;
      bd_rd = 1'b0;
      bd_wr = 1'b0;
      script = 2'd0;
      new_test = 1'b0;
      errors = 0;
      failed_tests = 0;
      n_tests = 0;
      card_ready = 1'b0;
      trace_ready = 1'b0;
      void'($urandom(32'hc57f));
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      fd = $fopen("sim/block_dev_trace.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the trace file sim/block_dev_trace.txt");
         $display("Regression failed");
         $finish;
      end
      else
      begin
         while ($fgets(line, fd) > 0)
         begin
            if (line.len() > 1 && line.substr(0, 0) != "#")
            begin
               n = $sscanf(line, "%s %d %h %d %d", name_v, op_v, addr_v, scr_v, err_v);
               if (n == 5)
               begin
                  t_names.push_back(name_v);
                  t_ops.push_back(op_v);
                  t_addrs.push_back(addr_v);
                  t_scripts.push_back(scr_v);
                  t_errs.push_back(err_v);
               end
            end
         end
         $fclose(fd);
         n_tests = t_names.size();
         trace_ready = 1'b1;
         for (int t = 0; t < n_tests; t++)
         begin
            test_name = t_names[t];
            run_test(t_ops[t], t_addrs[t], t_scripts[t], t_errs[t]);
            if (test_errs == 0)
               $display("test %s: ok", test_name);
            else
            begin
               $display("test %s: %0d mismatches", test_name, test_errs);
               failed_tests++;
            end
         end
         if (n_tests == 0)
            $display("The trace file holds no tests");
         $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                  n_tests, n_tests - failed_tests, failed_tests, errors);
         if (errors == 0 && n_tests > 0)
            $display("Regression passed");
         else
            $display("Regression failed");
         $finish;
      end
   end

   // Limit scales with the number of tests in the trace.
   initial
   begin
      wait (trace_ready);
      #(n_tests * per_test_cycles * clk_period);
      $display("Timeout: the run took longer than the limit for %0d tests", n_tests);
      $display("Regression failed");
      $finish;
   end

endmodule

/* compile.f */
logic/mmc_proto_pkg.sv
logic/block_dev_pkg.sv
logic/block_dev_ifs.sv
logic/bd_request_capture.sv
logic/card_sequencer.sv
logic/block_data_path.sv
logic/mmc_block_dev.sv
sim/card_model.sv
sim/tb_mmc_block_dev.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_mmc_block_dev
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/block_dev_trace.txt */
# name  opcode(0 reset 1 read 2 write 3 reserved)  block_addr(hex)  card_script  expected_err
# card_script 0 normal, 1 CMD1 answers 05 once, 2 block R1 is 04, 3 data response 0b
read_cold        1 000123 0 0
reset_retry      0 000000 1 0
write_pair       2 0004a7 0 0
read_r1_error    1 000010 2 1
read_after_err   1 000011 0 0
write_bad_dresp  2 000200 3 1
read_warm        1 0004a7 0 0
read_high_bit    1 800003 0 0
write_top        2 7fffff 0 0
reserved_op      3 000055 0 0
